//--- source/gpio_consts.svh
// ~~~~~~~~~~~~~~~~~~~~
// GPIO board constants
// Pad count, function select width and UART pad positions
// ~~~~~~~~~~~~~~~~~~~~

`ifndef GPIO_CONSTS_SVH
`define GPIO_CONSTS_SVH

// Pads served by the block
`define GPIO_N_PADS 16

// Bits of function select per pad
`define GPIO_W_FSEL 1

// Fixed peripheral pads on the board
`define GPIO_UART_TX_PAD 15
`define GPIO_UART_RX_PAD 14

// APB address width
`define GPIO_ADDR_W 16

`endif

//--- source/gpio_reg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// GPIO register-side types
// Register offsets and APB phase encoding
// ~~~~~~~~~~~~~~~~~~~~

`include "gpio_consts.svh"

package gpio_reg_pkg;

	// Register offsets on the APB port
	typedef enum logic [`GPIO_ADDR_W-1:0] {
		REG_OUT  = 'h00,
		REG_DIR  = 'h04,
		REG_IN   = 'h08,
		REG_FSEL = 'h0c
	} reg_addr_t;

	// Bus phase seen in the previous cycle
	typedef enum logic [1:0] {
		APB_IDLE,
		APB_SETUP,
		APB_ACCESS
	} apb_state_t;

endpackage

//--- source/gpio_pad_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// GPIO pad-side types
// Per-pad function select encoding
// ~~~~~~~~~~~~~~~~~~~~

`include "gpio_consts.svh"

package gpio_pad_pkg;

	// Source of a pad's output and enable
	typedef enum logic [`GPIO_W_FSEL-1:0] {
		// Driven from OUT and DIR
		FSEL_PROC   = 'd0,
		// Driven by the attached peripheral
		FSEL_PERIPH = 'd1
	} fsel_t;

endpackage

//--- source/gpio_apb_slave.sv
// ~~~~~~~~~~~~~~~~~~~~
// GPIO APB slave
// Tracks bus phases, decodes offsets, returns ready, error and read data
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "gpio_consts.svh"

module gpio_apb_slave (
	input  logic                      clk,
	input  logic                      rst_i,

	input  logic                      psel_i,
	input  logic                      penable_i,
	input  logic                      pwrite_i,
	input  logic [`GPIO_ADDR_W-1:0]   paddr_i,
	input  logic [31:0]               pwdata_i,

	input  logic [31:0]               out_val_i,
	input  logic [31:0]               dir_val_i,
	input  logic [31:0]               in_val_i,
	input  logic [31:0]               fsel_val_i,

	output logic [31:0]               prdata_o,
	output logic                      pready_o,
	output logic                      pslverr_o,
	output logic                      wr_en_o,
	output gpio_reg_pkg::reg_addr_t   reg_sel_o,
	output logic [31:0]               wdata_o
);

	import gpio_reg_pkg::*;

	apb_state_t state_q;
	logic       access;
	logic       addr_hit;
	logic       legal;
	logic [31:0] rd_val;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= APB_IDLE;
		end else if (!psel_i) begin
			state_q <= APB_IDLE;
		end else if (!penable_i) begin
			state_q <= APB_SETUP;
		end else begin
			state_q <= APB_ACCESS;
		end
	end

	// Access phase only counts straight after a setup phase
	assign access = psel_i && penable_i && (state_q == APB_SETUP);

	always_comb begin
		addr_hit = 1'b1;
		rd_val = 32'h0;
		case (paddr_i)
			REG_OUT:  rd_val = out_val_i;
			REG_DIR:  rd_val = dir_val_i;
			REG_IN:   rd_val = in_val_i;
			REG_FSEL: rd_val = fsel_val_i;
			default:  addr_hit = 1'b0;
		endcase
	end

	// IN is read only
	assign legal = addr_hit && !(pwrite_i && (paddr_i == REG_IN));

	assign pready_o  = access;
	assign pslverr_o = access && !legal;
	assign wr_en_o   = access && legal && pwrite_i;
	assign reg_sel_o = reg_addr_t'(paddr_i);
	assign wdata_o   = pwdata_i;
	assign prdata_o  = (access && legal && !pwrite_i) ? rd_val : 32'h0;

endmodule

//--- source/gpio_regs.sv
// ~~~~~~~~~~~~~~~~~~~~
// GPIO register block
// OUT, DIR and FSEL registers plus synchronized pad inputs
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "gpio_consts.svh"

module gpio_regs (
	input  logic                                 clk,
	input  logic                                 rst_i,

	input  logic                                 wr_en_i,
	input  gpio_reg_pkg::reg_addr_t              reg_sel_i,
	input  logic [31:0]                          wdata_i,
	input  logic [`GPIO_N_PADS-1:0]              pad_in_i,

	output logic [31:0]                          out_val_o,
	output logic [31:0]                          dir_val_o,
	output logic [31:0]                          in_val_o,
	output logic [31:0]                          fsel_val_o,

	output logic [`GPIO_N_PADS-1:0]              proc_out_o,
	output logic [`GPIO_N_PADS-1:0]              proc_oe_o,
	output gpio_pad_pkg::fsel_t [`GPIO_N_PADS-1:0] fsel_o
);

	import gpio_reg_pkg::*;
	import gpio_pad_pkg::*;

	localparam int W_FSEL_ALL = `GPIO_N_PADS * `GPIO_W_FSEL;

	logic [`GPIO_N_PADS-1:0] out_q;
	logic [`GPIO_N_PADS-1:0] dir_q;
	logic [W_FSEL_ALL-1:0]   fsel_q;
	logic [`GPIO_N_PADS-1:0] in_meta_q;
	logic [`GPIO_N_PADS-1:0] in_q;

	// Strobes are already qualified by the slave
	always_ff @(posedge clk) begin
		if (rst_i) begin
			out_q  <= '0;
			dir_q  <= '0;
			fsel_q <= '0;
		end else if (wr_en_i) begin
			case (reg_sel_i)
				REG_OUT:  out_q  <= wdata_i[`GPIO_N_PADS-1:0];
				REG_DIR:  dir_q  <= wdata_i[`GPIO_N_PADS-1:0];
				REG_FSEL: fsel_q <= wdata_i[W_FSEL_ALL-1:0];
				default: ;
			endcase
		end
	end

	// Two-flop synchronizer for the pad inputs
	always_ff @(posedge clk) begin
		in_meta_q <= pad_in_i;
		in_q      <= in_meta_q;
	end

	assign out_val_o  = {{(32 - `GPIO_N_PADS){1'b0}}, out_q};
	assign dir_val_o  = {{(32 - `GPIO_N_PADS){1'b0}}, dir_q};
	assign in_val_o   = {{(32 - `GPIO_N_PADS){1'b0}}, in_q};
	assign fsel_val_o = {{(32 - W_FSEL_ALL){1'b0}}, fsel_q};

	assign proc_out_o = out_q;
	assign proc_oe_o  = dir_q;

	// Unpack one select field per pad
	always_comb begin
		for (int i = 0; i < `GPIO_N_PADS; i++) begin
			fsel_o[i] = fsel_t'(fsel_q[i*`GPIO_W_FSEL +: `GPIO_W_FSEL]);
		end
	end

endmodule

//--- source/gpio_pad_mux.sv
// ~~~~~~~~~~~~~~~~~~~~
// GPIO pad multiplexer
// Picks processor or peripheral drive per pad, taps UART receive
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "gpio_consts.svh"

module gpio_pad_mux (
	input  logic [`GPIO_N_PADS-1:0]              proc_out_i,
	input  logic [`GPIO_N_PADS-1:0]              proc_oe_i,
	input  gpio_pad_pkg::fsel_t [`GPIO_N_PADS-1:0] fsel_i,
	input  logic                                 uart_tx_i,
	input  logic [`GPIO_N_PADS-1:0]              pad_in_i,

	output logic [`GPIO_N_PADS-1:0]              pad_out_o,
	output logic [`GPIO_N_PADS-1:0]              pad_oe_o,
	output logic                                 uart_rx_o
);

	import gpio_pad_pkg::*;

	logic [`GPIO_N_PADS-1:0] periph_out;

	// Peripheral side. Only the TX pad has a driver
	always_comb begin
		periph_out = '0;
		periph_out[`GPIO_UART_TX_PAD] = uart_tx_i;
	end

	always_comb begin
		for (int i = 0; i < `GPIO_N_PADS; i++) begin
			if (fsel_i[i] == FSEL_PERIPH) begin
				pad_out_o[i] = periph_out[i];
				// Enabled only where a peripheral drives
				pad_oe_o[i]  = (i == `GPIO_UART_TX_PAD);
			end else begin
				pad_out_o[i] = proc_out_i[i];
				pad_oe_o[i]  = proc_oe_i[i];
			end
		end
	end

	// Receive pad feeds the UART directly without a synchronizer
	assign uart_rx_o = pad_in_i[`GPIO_UART_RX_PAD];

endmodule

//--- source/gpio.sv
// ~~~~~~~~~~~~~~~~~~~~
// GPIO top level
// APB slave, register block and pad mux
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "gpio_consts.svh"

module gpio (
	input  logic                       clk,
	input  logic                       rst_i,

	input  logic                       psel_i,
	input  logic                       penable_i,
	input  logic                       pwrite_i,
	input  logic [`GPIO_ADDR_W-1:0]    paddr_i,
	input  logic [31:0]                pwdata_i,
	output logic [31:0]                prdata_o,
	output logic                       pready_o,
	output logic                       pslverr_o,

	input  logic [`GPIO_N_PADS-1:0]    pad_in_i,
	output logic [`GPIO_N_PADS-1:0]    pad_out_o,
	output logic [`GPIO_N_PADS-1:0]    pad_oe_o,

	input  logic                       uart_tx_i,
	output logic                       uart_rx_o
);

	import gpio_reg_pkg::*;
	import gpio_pad_pkg::*;

	logic [31:0]             out_val;
	logic [31:0]             dir_val;
	logic [31:0]             in_val;
	logic [31:0]             fsel_val;
	logic                    wr_en;
	reg_addr_t               reg_sel;
	logic [31:0]             wdata;
	logic [`GPIO_N_PADS-1:0] proc_out;
	logic [`GPIO_N_PADS-1:0] proc_oe;
	fsel_t [`GPIO_N_PADS-1:0] fsel;

	gpio_apb_slave apb_slave_i (
		.clk        (clk),
		.rst_i      (rst_i),
		.psel_i     (psel_i),
		.penable_i  (penable_i),
		.pwrite_i   (pwrite_i),
		.paddr_i    (paddr_i),
		.pwdata_i   (pwdata_i),
		.out_val_i  (out_val),
		.dir_val_i  (dir_val),
		.in_val_i   (in_val),
		.fsel_val_i (fsel_val),
		.prdata_o   (prdata_o),
		.pready_o   (pready_o),
		.pslverr_o  (pslverr_o),
		.wr_en_o    (wr_en),
		.reg_sel_o  (reg_sel),
		.wdata_o    (wdata)
	);

	gpio_regs regs_i (
		.clk        (clk),
		.rst_i      (rst_i),
		.wr_en_i    (wr_en),
		.reg_sel_i  (reg_sel),
		.wdata_i    (wdata),
		.pad_in_i   (pad_in_i),
		.out_val_o  (out_val),
		.dir_val_o  (dir_val),
		.in_val_o   (in_val),
		.fsel_val_o (fsel_val),
		.proc_out_o (proc_out),
		.proc_oe_o  (proc_oe),
		.fsel_o     (fsel)
	);

	gpio_pad_mux pad_mux_i (
		.proc_out_i (proc_out),
		.proc_oe_i  (proc_oe),
		.fsel_i     (fsel),
		.uart_tx_i  (uart_tx_i),
		.pad_in_i   (pad_in_i),
		.pad_out_o  (pad_out_o),
		.pad_oe_o   (pad_oe_o),
		.uart_rx_o  (uart_rx_o)
	);

endmodule

//--- tb/gpio_assert.sv
// ~~~~~~~~~~~~~~~~~~~~
// GPIO protocol and pad muxing assertions, bound to the top level
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "gpio_consts.svh"

module gpio_assert (
	input  logic                    clk,
	input  logic                    rst_i,
	input  logic                    psel_i,
	input  logic                    penable_i,
	input  logic                    pready_i,
	input  logic                    pslverr_i,
	input  logic                    uart_tx_i,
	input  logic [`GPIO_N_PADS-1:0] pad_out_i,
	input  logic [`GPIO_N_PADS-1:0] pad_oe_i,
	input  logic [31:0]             fsel_val_i
);

	localparam int TX_FSEL_BIT = `GPIO_UART_TX_PAD * `GPIO_W_FSEL;

	// Failures seen so far, polled by the testbench
	int unsigned fail_cnt = 0;

	ready_in_access: assert property (
		@(posedge clk) disable iff (rst_i)
		pready_i |-> (psel_i && penable_i)
	) else begin
		$error("pready high outside an APB access phase");
		fail_cnt++;
	end

	err_with_ready: assert property (
		@(posedge clk) disable iff (rst_i)
		pslverr_i |-> pready_i
	) else begin
		$error("pslverr high without pready");
		fail_cnt++;
	end

	// TX pad handed to the UART
	tx_pad_follows_uart: assert property (
		@(posedge clk) disable iff (rst_i)
		fsel_val_i[TX_FSEL_BIT] |->
			(pad_out_i[`GPIO_UART_TX_PAD] == uart_tx_i) && pad_oe_i[`GPIO_UART_TX_PAD]
	) else begin
		$error("TX pad does not follow uart_tx with its enable high");
		fail_cnt++;
	end

	oe_clear_after_reset: assert property (
		@(posedge clk)
		rst_i |=> (pad_oe_i == '0)
	) else begin
		$error("pad output enables not cleared after reset");
		fail_cnt++;
	end

endmodule

bind gpio gpio_assert asserts_i (
	.clk        (clk),
	.rst_i      (rst_i),
	.psel_i     (psel_i),
	.penable_i  (penable_i),
	.pready_i   (pready_o),
	.pslverr_i  (pslverr_o),
	.uart_tx_i  (uart_tx_i),
	.pad_out_i  (pad_out_o),
	.pad_oe_i   (pad_oe_o),
	.fsel_val_i (fsel_val)
);

//--- tb/gpio_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// GPIO testbench: APB register access, input sync, pad muxing, errors
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "gpio_consts.svh"

module gpio_tb;

	import gpio_reg_pkg::*;

	localparam int          SEED           = 78408;
	localparam int          TIMEOUT_CYCLES = 2000;
	localparam logic [31:0] LOW_MASK       = 32'h0000_ffff;

	logic                    clk;
	logic                    rst_i;
	logic                    psel;
	logic                    penable;
	logic                    pwrite;
	logic [`GPIO_ADDR_W-1:0] paddr;
	logic [31:0]             pwdata;
	logic [31:0]             prdata;
	logic                    pready;
	logic                    pslverr;
	logic [`GPIO_N_PADS-1:0] pad_in;
	logic [`GPIO_N_PADS-1:0] pad_out;
	logic [`GPIO_N_PADS-1:0] pad_oe;
	logic                    uart_tx;
	logic                    uart_rx;

	// Register contents as the testbench expects them
	logic [`GPIO_N_PADS-1:0] exp_out;
	logic [`GPIO_N_PADS-1:0] exp_dir;
	logic [`GPIO_N_PADS-1:0] exp_fsel;

	int cycle_cnt = 0;

	gpio gpio_i (
		.clk       (clk),
		.rst_i     (rst_i),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr),
		.pad_in_i  (pad_in),
		.pad_out_o (pad_out),
		.pad_oe_o  (pad_oe),
		.uart_tx_i (uart_tx),
		.uart_rx_o (uart_rx)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			abort_run("value check failed");
		end
	endtask

	// Periph pads drive zero unless they carry UART transmit
	function automatic logic [`GPIO_N_PADS-1:0] expect_pad_out(
		input logic [`GPIO_N_PADS-1:0] out_v,
		input logic [`GPIO_N_PADS-1:0] fsel_v,
		input logic                    tx
	);
		logic [`GPIO_N_PADS-1:0] r;
		r = out_v & ~fsel_v;
		if (fsel_v[`GPIO_UART_TX_PAD])
			r[`GPIO_UART_TX_PAD] = tx;
		return r;
	endfunction

	function automatic logic [`GPIO_N_PADS-1:0] expect_pad_oe(
		input logic [`GPIO_N_PADS-1:0] dir_v,
		input logic [`GPIO_N_PADS-1:0] fsel_v
	);
		logic [`GPIO_N_PADS-1:0] r;
		r = dir_v & ~fsel_v;
		if (fsel_v[`GPIO_UART_TX_PAD])
			r[`GPIO_UART_TX_PAD] = 1'b1;
		return r;
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			psel    = 1'b0;
			penable = 1'b0;
			pwrite  = 1'b0;
		end
	endtask

	// Setup then access, sampled mid-cycle; returns just after the closing edge
	task automatic apb_access(
		input  logic                    wr,
		input  logic [`GPIO_ADDR_W-1:0] addr,
		input  logic [31:0]             wdata,
		output logic [31:0]             rdata,
		output logic                    err
	);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		#1;
		rdata = prdata;
		err   = pslverr;
		check_val("apb pready", 32'd1, pready);
		@(posedge clk);
		#1;
	endtask

	task automatic write_ok(input string name, input logic [15:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic        err;
		apb_access(1'b1, addr, data, rd, err);
		check_val({name, " pslverr"}, 32'd0, err);
	endtask

	task automatic read_expect(input string name, input logic [15:0] addr, input logic [31:0] exp);
		logic [31:0] rd;
		logic        err;
		apb_access(1'b0, addr, 32'h0, rd, err);
		check_val({name, " pslverr"}, 32'd0, err);
		check_val({name, " prdata"}, exp, rd);
	endtask

	task automatic error_expect(input string name, input logic wr, input logic [15:0] addr);
		logic [31:0] rd;
		logic        err;
		apb_access(wr, addr, 32'hffff_ffff, rd, err);
		check_val({name, " pslverr"}, 32'd1, err);
		check_val({name, " prdata"}, 32'd0, rd);
	endtask

	task automatic check_pads(input string name);
		check_val({name, " pad_out"}, expect_pad_out(exp_out, exp_fsel, uart_tx), pad_out);
		check_val({name, " pad_oe"}, expect_pad_oe(exp_dir, exp_fsel), pad_oe);
	endtask

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			abort_run("Timeout: run did not finish within the cycle limit");
	end

	always @(negedge clk) begin
		if (gpio_i.asserts_i.fail_cnt != 0)
			abort_run("A bound protocol or pad muxing assertion failed");
	end

	initial begin : main_seq
		logic [31:0] wval;
		rst_i    = 1'b1;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		pad_in   = '0;
		uart_tx  = 1'b0;
		exp_out  = '0;
		exp_dir  = '0;
		exp_fsel = '0;
		void'($urandom(SEED));

		repeat (16) @(negedge clk);
		rst_i = 1'b0;
		#1;

		// Reset state
		check_pads("reset");
		read_expect("reset out", REG_OUT, 32'h0);
		read_expect("reset dir", REG_DIR, 32'h0);
		read_expect("reset fsel", REG_FSEL, 32'h0);

		// Processor path with every pad on FSEL_PROC
		for (int i = 0; i < 40; i++) begin
			wval = $urandom;
			write_ok("out write", REG_OUT, wval);
			exp_out = wval[`GPIO_N_PADS-1:0];
			read_expect("out readback", REG_OUT, wval & LOW_MASK);
			wval = $urandom;
			write_ok("dir write", REG_DIR, wval);
			exp_dir = wval[`GPIO_N_PADS-1:0];
			read_expect("dir readback", REG_DIR, wval & LOW_MASK);
			check_pads("proc path");
		end

		// Random function selects
		for (int i = 0; i < 40; i++) begin
			idle_cycles(1);
			wval = $urandom;
			uart_tx = wval[0];
			wval = $urandom;
			write_ok("fsel write", REG_FSEL, wval);
			exp_fsel = wval[`GPIO_N_PADS-1:0];
			read_expect("fsel readback", REG_FSEL, wval & LOW_MASK);
			check_pads("fsel mix");
		end
		write_ok("fsel clear", REG_FSEL, 32'h0);
		exp_fsel = '0;

		// Input synchronizer and UART receive tap
		for (int i = 0; i < 20; i++) begin
			idle_cycles(1);
			wval = $urandom;
			pad_in = wval[`GPIO_N_PADS-1:0];
			#1;
			check_val("uart_rx tap", pad_in[`GPIO_UART_RX_PAD], uart_rx);
			idle_cycles(3);
			read_expect("in readback", REG_IN, {16'h0, pad_in});
		end

		// TX pad, RX pad and pad 0 on the peripheral
		write_ok("fsel periph", REG_FSEL, 32'h0000_c001);
		exp_fsel = 16'hc001;
		for (int i = 0; i < 10; i++) begin
			wval = $urandom;
			write_ok("periph out write", REG_OUT, wval);
			exp_out = wval[`GPIO_N_PADS-1:0];
			wval = $urandom;
			write_ok("periph dir write", REG_DIR, wval);
			exp_dir = wval[`GPIO_N_PADS-1:0];
			for (int j = 0; j < 3; j++) begin
				idle_cycles(1);
				uart_tx = ~uart_tx;
				wval = $urandom;
				pad_in = wval[`GPIO_N_PADS-1:0];
				#1;
				check_pads("periph mux");
				check_val("periph uart_rx", pad_in[`GPIO_UART_RX_PAD], uart_rx);
			end
		end

		// Illegal accesses leave every register alone
		error_expect("unmapped read", 1'b0, 16'h0010);
		error_expect("unmapped write", 1'b1, 16'h0010);
		error_expect("misaligned read", 1'b0, 16'h0002);
		error_expect("high write", 1'b1, 16'hfffc);
		error_expect("in write", 1'b1, REG_IN);
		read_expect("out after errors", REG_OUT, {16'h0, exp_out});
		read_expect("dir after errors", REG_DIR, {16'h0, exp_dir});
		read_expect("fsel after errors", REG_FSEL, {16'h0, exp_fsel});
		read_expect("in after errors", REG_IN, {16'h0, pad_in});
		check_pads("after errors");

		idle_cycles(4);
		if (gpio_i.asserts_i.fail_cnt == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			abort_run("Bound assertions reported failures");
		end
	end

endmodule

//--- project.f
+incdir+source
source/gpio_reg_pkg.sv
source/gpio_pad_pkg.sv
source/gpio_apb_slave.sv
source/gpio_regs.sv
source/gpio_pad_mux.sv
source/gpio.sv
tb/gpio_assert.sv
tb/gpio_tb.sv
